// ==== async_fifo.f ====
+incdir+rtl
rtl/async_fifo_pkg.sv
rtl/fifo_ram_if.sv
rtl/pulse_cross.sv
rtl/fifo_write_side.sv
rtl/fifo_read_side.sv
rtl/fifo_dist_ram.sv
rtl/async_fifo.sv
tests/tb_async_fifo.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the async FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f async_fifo.f --top-module tb_async_fifo -o tb_async_fifo

out=$(./obj_dir/tb_async_fifo)
echo "$out"

if echo "$out" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1

// ==== tests/tb_async_fifo.sv ====
// async FIFO testbench
//   clk_a and clk_b generators, reset and clear
//   LFSR driven random writes and reads
//   queue reference model with ordered read checks
//   fill, drop, drain and settled status checks
//   watchdog and closing summary

`timescale 1ns/1ps
`default_nettype none

`include "async_fifo_defs.svh"

module tb_async_fifo import async_fifo_pkg::*; ();

	localparam int DEPTH = 1 << `FIFO_ADDR_W;
	localparam int AF_LEVEL = DEPTH - `FIFO_AF_THRESHOLD;
	localparam int B_PERIOD = 26;
	localparam int RAND_CYCLES = 400;
	// each crossing event needs about 6 slow cycles of round trip
	localparam int SETTLE_CYCLES = 12 * DEPTH;
	// random phase plus generous room for every settle and drain
	localparam int TIMEOUT_NS = (RAND_CYCLES + (DEPTH + 12) * 2 * SETTLE_CYCLES) * B_PERIOD;

	logic       clk_a;
	logic       clk_b;
	logic       arst_n;
	logic       clr_a;
	logic       clr_b;
	logic       write;
	fifo_data_t write_data;
	logic       read;
	fifo_data_t read_data;
	logic       empty;
	logic       almost_full;
	logic       full;

	// reference contents, head at index 0
	fifo_data_t  model [$];
	logic [31:0] lfsr_state = 32'h6dde_05e6;
	int          checks = 0;
	int          errors = 0;
	int          reads = 0;

	async_fifo i_async_fifo (
		.clk_a       (clk_a),
		.clk_b       (clk_b),
		.arst_n      (arst_n),
		.clr_a       (clr_a),
		.clr_b       (clr_b),
		.write       (write),
		.write_data  (write_data),
		.read        (read),
		.read_data   (read_data),
		.empty       (empty),
		.almost_full (almost_full),
		.full        (full)
	);

	initial begin
		clk_a = 1'b0;
		forever #10 clk_a = ~clk_a;
	end

	// slower reader clock
	initial begin
		clk_b = 1'b0;
		forever #13 clk_b = ~clk_b;
	end

	// galois form, taps for x^32+x^22+x^2+x+1
	function automatic logic lfsr_bit();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb) begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return lsb;
	endfunction

	function automatic fifo_data_t rand_word();
		fifo_data_t word;
		word = '0;
		for (int i = 0; i < `FIFO_DATA_W; i++) begin
			word = {word[`FIFO_DATA_W-2:0], lfsr_bit()};
		end
		return word;
	endfunction

	task automatic check_flag(input string name, input logic got, input logic expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("[ERROR] %s: got %h expected %h", name, got, expected);
		end
	endtask

	task automatic check_count(input string name, input int got, input int expected);
		checks++;
		assert (got == expected) else begin
			errors++;
			$display("[ERROR] %s: got %h expected %h", name, got, expected);
		end
	endtask

	// flags against the model once nothing is in flight
	task automatic check_settled();
		check_flag("full", full, model.size() == DEPTH);
		check_flag("empty", empty, model.size() == 0);
		check_flag("almost_full", almost_full, model.size() >= AF_LEVEL);
	endtask

	// both sides idle until every crossing has finished
	task automatic settle();
		repeat (SETTLE_CYCLES) @(posedge clk_b);
		#2;
	endtask

	task automatic write_word(input fifo_data_t word);
		@(posedge clk_a);
		#2;
		write = 1'b1;
		write_data = word;
		@(posedge clk_a);
		#2;
		write = 1'b0;
	endtask

	task automatic random_writes(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk_a);
			#2;
			write = lfsr_bit();
			write_data = rand_word();
		end
		@(posedge clk_a);
		#2;
		write = 1'b0;
	endtask

	// enables drawn up front, writer draws only on its own edges
	task automatic random_reads(input int cycles);
		logic en [$];
		for (int i = 0; i < cycles; i++) begin
			en.push_back(lfsr_bit());
		end
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk_b);
			#2;
			read = en[i];
		end
		@(posedge clk_b);
		#2;
		read = 1'b0;
	endtask

	// read every cycle until the DUT reports empty
	task automatic drain();
		@(posedge clk_b);
		#2;
		read = 1'b1;
		while (!empty) begin
			@(posedge clk_b);
			#2;
		end
		read = 1'b0;
	endtask

	task automatic clear_both();
		@(posedge clk_b);
		#2;
		clr_b = 1'b1;
		@(posedge clk_a);
		#2;
		clr_a = 1'b1;
		repeat (3) @(posedge clk_b);
		#2;
		clr_b = 1'b0;
		@(posedge clk_a);
		#2;
		clr_a = 1'b0;
		model.delete();
	endtask

	// write model, push what the write side can take
	always @(posedge clk_a) begin
		if (arst_n && !clr_a && write && !full) begin
			model.push_back(write_data);
		end
	end

	// read model, head word compared at the accepting edge
	always @(posedge clk_b) begin : read_monitor
		fifo_data_t head;
		if (arst_n && !clr_b && read && !empty) begin
			reads++;
			checks++;
			assert (model.size() != 0) else begin
				errors++;
				$display("read accepted while the model holds no words");
			end
			if (model.size() != 0) begin
				head = model.pop_front();
				checks++;
				assert (read_data === head) else begin
					errors++;
					$display("[ERROR] read_data: got %h expected %h", read_data, head);
				end
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired before the tests finished");
		$display("Regression failed");
		$finish;
	end

	initial begin : main
		int start;
		int fills;
		arst_n = 1'b0;
		clr_a = 1'b0;
		clr_b = 1'b0;
		write = 1'b0;
		write_data = '0;
		read = 1'b0;
		repeat (3) @(posedge clk_a);
		#2;
		arst_n = 1'b1;
		@(posedge clk_b);
		#2;
		check_flag("empty", empty, 1'b1);
		check_flag("full", full, 1'b0);
		check_flag("almost_full", almost_full, 1'b0);

		// concurrent traffic, writer outpaces the crossing
		fork
			random_writes(RAND_CYCLES);
			random_reads(RAND_CYCLES);
		join
		settle();
		check_settled();
		drain();
		settle();
		check_settled();

		// partial fill, then clear both domains
		for (int i = 0; i < 5; i++) begin
			write_word(rand_word());
		end
		settle();
		check_settled();
		clear_both();
		@(posedge clk_b);
		#2;
		check_flag("empty", empty, 1'b1);
		check_flag("full", full, 1'b0);
		check_flag("almost_full", almost_full, 1'b0);

		// fill one word at a time until full rises
		fills = 0;
		while (!full) begin
			write_word(rand_word());
			fills++;
			settle();
			check_settled();
		end
		check_count("fill writes", fills, DEPTH);
		check_count("model size", model.size(), DEPTH);

		// a write while full must not land
		write_word(rand_word());
		settle();
		check_count("model size", model.size(), DEPTH);
		check_settled();

		start = reads;
		drain();
		settle();
		check_count("drained words", reads - start, DEPTH);
		check_settled();

		// a read while empty must not consume the next word
		@(posedge clk_b);
		#2;
		read = 1'b1;
		repeat (3) @(posedge clk_b);
		#2;
		read = 1'b0;
		write_word(rand_word());
		settle();
		check_settled();
		start = reads;
		drain();
		settle();
		check_count("words after empty read", reads - start, 1);
		check_settled();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/async_fifo.sv ====
// async FIFO top
//   write side on clk_a, read side on clk_b
//   sync_wr and sync_rd event crossings
//   distributed RAM storage on a shared port bundle

`timescale 1ns/1ps
`default_nettype none

module async_fifo import async_fifo_pkg::*; (
	input  logic       clk_a,
	input  logic       clk_b,
	input  logic       arst_n,
	input  logic       clr_a,
	input  logic       clr_b,
	input  logic       write,
	input  fifo_data_t write_data,
	input  logic       read,
	output fifo_data_t read_data,
	output logic       empty,
	output logic       almost_full,
	output logic       full
);

	// accepted operations, each in its own domain
	logic wr_accept;
	logic rd_accept;
	// the same events after crossing
	logic wr_seen;
	logic rd_seen;

	fifo_ram_if ram_bus ();

	fifo_write_side i_write_side (
		.clk_a       (clk_a),
		.arst_n      (arst_n),
		.clr_a       (clr_a),
		.write       (write),
		.write_data  (write_data),
		.rd_seen     (rd_seen),
		.ram         (ram_bus.wr),
		.wr_accept   (wr_accept),
		.full        (full),
		.almost_full (almost_full)
	);

	// writes into the read domain
	pulse_cross sync_wr (
		.clk_src   (clk_a),
		.clk_dst   (clk_b),
		.arst_n    (arst_n),
		.clr_src   (clr_a),
		.clr_dst   (clr_b),
		.pulse_in  (wr_accept),
		.pulse_out (wr_seen)
	);

	// reads back into the write domain
	pulse_cross sync_rd (
		.clk_src   (clk_b),
		.clk_dst   (clk_a),
		.arst_n    (arst_n),
		.clr_src   (clr_b),
		.clr_dst   (clr_a),
		.pulse_in  (rd_accept),
		.pulse_out (rd_seen)
	);

	fifo_read_side i_read_side (
		.clk_b     (clk_b),
		.arst_n    (arst_n),
		.clr_b     (clr_b),
		.read      (read),
		.wr_seen   (wr_seen),
		.ram       (ram_bus.rd),
		.read_data (read_data),
		.rd_accept (rd_accept),
		.empty     (empty)
	);

	fifo_dist_ram i_dist_ram (
		.clk_a (clk_a),
		.ram   (ram_bus.mem)
	);

endmodule

`default_nettype wire

// ==== rtl/fifo_dist_ram.sv ====
// async FIFO storage
//   distributed RAM, depth 2**FIFO_ADDR_W
//   synchronous write on clk_a, unregistered read

`timescale 1ns/1ps
`default_nettype none

`include "async_fifo_defs.svh"

module fifo_dist_ram import async_fifo_pkg::*; (
	input  logic     clk_a,
	fifo_ram_if.mem  ram
);

	localparam int DEPTH = 1 << `FIFO_ADDR_W;

	// contents are not cleared
	fifo_data_t mem [DEPTH];

	always_ff @(posedge clk_a) begin
		if (ram.wr_en) begin
			mem[ram.wr_addr] <= ram.wr_data;
		end
	end

	// read address from clk_b side, word valid long before wr_seen lands
	assign ram.rd_data = mem[ram.rd_addr];

endmodule

`default_nettype wire

// ==== rtl/fifo_read_side.sv ====
// async FIFO read side, clk_b domain
//   read gating against empty
//   read pointer onto the RAM read port
//   occupancy counter and empty flag

`timescale 1ns/1ps
`default_nettype none

module fifo_read_side import async_fifo_pkg::*; (
	input  logic          clk_b,
	input  logic          arst_n,
	input  logic          clr_b,
	input  logic          read,
	input  logic          wr_seen,
	fifo_ram_if.rd        ram,
	output fifo_data_t    read_data,
	output logic          rd_accept,
	output logic          empty
);

	fifo_addr_t  rd_ptr;
	fifo_count_t count;

	// reads while empty are dropped here
	assign rd_accept = read & ~empty;

	// head word straight from the RAM
	assign ram.rd_addr = rd_ptr;
	assign read_data   = ram.rd_data;

	always_ff @(posedge clk_b or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= '0;
			count  <= '0;
		end else if (clr_b) begin
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (rd_accept) begin
				rd_ptr <= rd_ptr + fifo_addr_t'(1);
			end
			// up on a crossed write, down on read, hold on both
			case ({wr_seen, rd_accept})
				2'b10:   count <= count + fifo_count_t'(1);
				2'b01:   count <= count - fifo_count_t'(1);
				default: count <= count;
			endcase
		end
	end

	assign empty = (count == '0);

endmodule

`default_nettype wire

// ==== rtl/fifo_write_side.sv ====
// async FIFO write side, clk_a domain
//   write gating against full
//   write pointer and RAM write port
//   occupancy counter, full and almost_full flags

`timescale 1ns/1ps
`default_nettype none

`include "async_fifo_defs.svh"

module fifo_write_side import async_fifo_pkg::*; (
	input  logic          clk_a,
	input  logic          arst_n,
	input  logic          clr_a,
	input  logic          write,
	input  fifo_data_t    write_data,
	input  logic          rd_seen,
	fifo_ram_if.wr        ram,
	output logic          wr_accept,
	output logic          full,
	output logic          almost_full
);

	localparam fifo_count_t DEPTH    = fifo_count_t'(1) << `FIFO_ADDR_W;
	localparam fifo_count_t AF_LEVEL = DEPTH - fifo_count_t'(`FIFO_AF_THRESHOLD);

	fifo_addr_t  wr_ptr;
	fifo_count_t count;
	fifo_count_t count_nxt;

	// writes while full are dropped here
	assign wr_accept = write & ~full;

	// RAM write port
	assign ram.wr_en   = wr_accept;
	assign ram.wr_addr = wr_ptr;
	assign ram.wr_data = write_data;

	// up on write, down on a read seen from clk_b
	always_comb begin
		case ({wr_accept, rd_seen})
			2'b10:   count_nxt = count + fifo_count_t'(1);
			2'b01:   count_nxt = count - fifo_count_t'(1);
			default: count_nxt = count;
		endcase
	end

	always_ff @(posedge clk_a or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr      <= '0;
			count       <= '0;
			almost_full <= 1'b0;
		end else if (clr_a) begin
			wr_ptr      <= '0;
			count       <= '0;
			almost_full <= 1'b0;
		end else begin
			// pointer wraps at depth
			if (wr_accept) begin
				wr_ptr <= wr_ptr + fifo_addr_t'(1);
			end
			count       <= count_nxt;
			// registered, tracks the count it is stored with
			almost_full <= (count_nxt >= AF_LEVEL);
		end
	end

	// count reaches depth only when full
	assign full = count[`FIFO_ADDR_W];

endmodule

`default_nettype wire

// ==== rtl/pulse_cross.sv ====
// single-cycle event crossing between two clock domains
//   pending-event counter on the source side
//   request toggle, two-flop sync into the destination
//   acknowledge toggle, two-flop sync back to the source

`timescale 1ns/1ps
`default_nettype none

module pulse_cross import async_fifo_pkg::*; (
	input  logic clk_src,
	input  logic clk_dst,
	input  logic arst_n,
	input  logic clr_src,
	input  logic clr_dst,
	input  logic pulse_in,
	output logic pulse_out
);

	// source side
	fifo_count_t pending;
	logic        req_tgl;
	logic        ack_meta;
	logic        ack_sync;
	logic        ack_last;
	logic        ack_edge;
	logic        busy;
	logic        launch;

	// destination side
	logic        req_meta;
	logic        req_sync;
	logic        ack_tgl;

	// ack toggle flipped since last look
	assign ack_edge = ack_sync ^ ack_last;
	// request out and not yet acknowledged
	assign busy = req_tgl ^ ack_last;
	// one handshake per pending event
	assign launch = (pending != '0) && !busy;

	always_ff @(posedge clk_src or negedge arst_n) begin
		if (!arst_n) begin
			pending  <= '0;
			req_tgl  <= 1'b0;
			ack_meta <= 1'b0;
			ack_sync <= 1'b0;
			ack_last <= 1'b0;
		end else if (clr_src) begin
			pending  <= '0;
			req_tgl  <= 1'b0;
			ack_meta <= 1'b0;
			ack_sync <= 1'b0;
			ack_last <= 1'b0;
		end else begin
			// new event and finished handshake cancel out
			case ({pulse_in, ack_edge})
				2'b10:   pending <= pending + fifo_count_t'(1);
				2'b01:   pending <= pending - fifo_count_t'(1);
				default: pending <= pending;
			endcase
			req_tgl  <= req_tgl ^ launch;
			// ack back from the destination
			ack_meta <= ack_tgl;
			ack_sync <= ack_meta;
			ack_last <= ack_sync;
		end
	end

	always_ff @(posedge clk_dst or negedge arst_n) begin
		if (!arst_n) begin
			req_meta <= 1'b0;
			req_sync <= 1'b0;
			ack_tgl  <= 1'b0;
		end else if (clr_dst) begin
			req_meta <= 1'b0;
			req_sync <= 1'b0;
			ack_tgl  <= 1'b0;
		end else begin
			req_meta <= req_tgl;
			req_sync <= req_meta;
			// ack follows the synced request one cycle later
			ack_tgl  <= req_sync;
		end
	end

	// high for the one cycle where request and ack differ
	assign pulse_out = req_sync ^ ack_tgl;

endmodule

`default_nettype wire

// ==== rtl/fifo_ram_if.sv ====
// storage port bundle between the FIFO sides and the RAM
//   write port from the clk_a side
//   read port from the clk_b side
//   modports wr, rd and mem

`timescale 1ns/1ps
`default_nettype none

interface fifo_ram_if import async_fifo_pkg::*; ();

	// write port, clk_a domain
	logic       wr_en;
	fifo_addr_t wr_addr;
	fifo_data_t wr_data;

	// read port, unregistered
	fifo_addr_t rd_addr;
	fifo_data_t rd_data;

	// write side drives the whole write port
	modport wr (output wr_en, output wr_addr, output wr_data);

	// read side steers the address, takes the word back
	modport rd (output rd_addr, input rd_data);

	// storage sees everything but the read word as input
	modport mem (input wr_en, input wr_addr, input wr_data, input rd_addr, output rd_data);

endinterface

`default_nettype wire

// ==== rtl/async_fifo_pkg.sv ====
// async FIFO shared types
//   fifo_data_t   stored word
//   fifo_addr_t   read or write pointer
//   fifo_count_t  occupancy and pending-event count

`default_nettype none

`include "async_fifo_defs.svh"

package async_fifo_pkg;

	// one word as written and read
	typedef logic [`FIFO_DATA_W-1:0] fifo_data_t;

	// ram address, wraps at depth
	typedef logic [`FIFO_ADDR_W-1:0] fifo_addr_t;

	// one extra bit so the count can reach depth
	typedef logic [`FIFO_ADDR_W:0] fifo_count_t;

endpackage

`default_nettype wire

// ==== rtl/async_fifo_defs.svh ====
// async FIFO configuration macros
//   data word width
//   address width, sets the FIFO depth
//   almost-full threshold below depth

`ifndef ASYNC_FIFO_DEFS_SVH
`define ASYNC_FIFO_DEFS_SVH

// width of one stored word
`define FIFO_DATA_W 32

// pointer width, depth is 2**FIFO_ADDR_W
`define FIFO_ADDR_W 4

// almost_full once count >= depth - threshold
`define FIFO_AF_THRESHOLD 4

`endif
